/* sw_status.f */
+incdir+logic
logic/sw_status_pkg.sv
logic/bus_write_decode.sv
logic/sim_sram_store.sv
logic/sw_status_tracker.sv
logic/test_result_report.sv
logic/dps_pad_mux.sv
logic/sw_status_top.sv
test/tb_sw_status.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_sw_status -Mdir "$BUILD_DIR" \
  -f sw_status.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_sw_status" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^>>> PASS\$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

/* test/tb_sw_status.sv */
/*
 * Testbench for the software test observer: bus stimulus, reference
 * models with delay lines, timed assertions, timeout and summary
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module tb_sw_status;
  import sw_status_pkg::*;

  // Generous budget over the few hundred cycles the tests take
  localparam int TIMEOUT_CYCLES = 4000;

  logic          clk = 1'b0;
  logic          reset_i = 1'b1;
  logic          bus_we_i = 1'b0;
  bus_addr_t     bus_addr_i = '0;
  bus_data_t     bus_data_i = '0;
  sram_index_t   rd_index_i = '0;
  logic          jtag_spi_n_i = 1'b1;
  logic          jtag_tck_i = 1'b0;
  logic          jtag_tms_i = 1'b0;
  logic          jtag_tdi_i = 1'b0;
  logic          spi_sck_i = 1'b0;
  logic          spi_csb_i = 1'b1;
  logic          spi_sdi_i = 1'b0;
  logic          dps_sdo_i = 1'b0;
  bus_data_t     rd_data_o;
  logic          jtag_tdo_o;
  logic          spi_sdo_o;
  logic [3:0]    dps_o;
  logic          test_done_o;
  logic          test_passed_o;
  status_state_e test_state_o;
  logic          log_valid_o;
  logic [7:0]    log_char_o;

  integer        seed = 32'h8bfc;
  int            assert_errors = 0;
  int            check_errors = 0;
  int            err_mark = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            cycle_count = 0;
  bus_data_t     model_mem [`SIM_SRAM_WORDS];
  // Expected results, delayed to the cycle the DUT shows them
  status_state_e st_m = Boot;
  status_state_e st_q1 = Boot;
  status_state_e st_q2 = Boot;
  logic [1:0]    res_m = '0;  // {passed, done}
  logic [1:0]    res_q1 = '0;
  logic [1:0]    res_q2 = '0;
  logic [8:0]    log_m = '0;  // {valid, char}
  logic [8:0]    log_q1 = '0;
  logic [8:0]    log_q2 = '0;
  logic          rd_chk = 1'b0;
  bus_data_t     rd_exp = '0;
  bus_data_t     rd_exp_q1 = '0;

  always #5 clk = ~clk;

  sw_status_top UUT (.*);

  // Registered read, one cycle after the index is sampled
  rd_data_check: assert property (@(posedge clk) disable iff (reset_i)
      rd_chk |=> (rd_data_o == rd_exp_q1))
    else begin
      assert_errors++;
      $display("ERROR rd_data_o expected %h got %h", rd_exp_q1, $sampled(rd_data_o));
    end

  // Status and log results two edges after the bus write is sampled
  state_check: assert property (@(posedge clk) disable iff (reset_i)
      test_state_o == st_q2)
    else begin
      assert_errors++;
      $display("ERROR test_state_o expected %h got %h", st_q2, $sampled(test_state_o));
    end

  done_check: assert property (@(posedge clk) disable iff (reset_i)
      test_done_o == res_q2[0])
    else begin
      assert_errors++;
      $display("ERROR test_done_o expected %h got %h", res_q2[0], $sampled(test_done_o));
    end

  passed_check: assert property (@(posedge clk) disable iff (reset_i)
      test_passed_o == res_q2[1])
    else begin
      assert_errors++;
      $display("ERROR test_passed_o expected %h got %h", res_q2[1], $sampled(test_passed_o));
    end

  log_valid_check: assert property (@(posedge clk) disable iff (reset_i)
      log_valid_o == log_q2[8])
    else begin
      assert_errors++;
      $display("ERROR log_valid_o expected %h got %h", log_q2[8], $sampled(log_valid_o));
    end

  log_char_check: assert property (@(posedge clk) disable iff (reset_i)
      log_q1[8] |=> (log_char_o == log_q2[7:0]))
    else begin
      assert_errors++;
      $display("ERROR log_char_o expected %h got %h", log_q2[7:0], $sampled(log_char_o));
    end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Advance to the next falling edge, shift the delay lines, clear strobes
  task automatic step(input int n);
    repeat (n) begin
      @(negedge clk);
      st_q2 = st_q1;
      st_q1 = st_m;
      res_q2 = res_q1;
      res_q1 = res_m;
      log_q2 = log_q1;
      log_q1 = log_m;
      rd_exp_q1 = rd_exp;
      log_m = '0;
      rd_chk = 1'b0;
      bus_we_i = 1'b0;
    end
  endtask

  function automatic bus_addr_t word_addr(input sram_index_t idx);
    return `SIM_SRAM_START + (bus_addr_t'(idx) << 2);
  endfunction

  // Status rules: start from Boot, end from InTest, failure ends from Boot too
  task automatic follow_status(input status_code_t code);
    if (st_m == Boot && code == `STATUS_IN_TEST) begin
      st_m = InTest;
    end else if ((st_m == Boot || st_m == InTest) && code == `STATUS_FAILED) begin
      st_m = Failed;
      res_m = 2'b01;
    end else if (st_m == InTest && code == `STATUS_PASSED) begin
      st_m = Passed;
      res_m = 2'b11;
    end
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    step(1);
    bus_we_i = 1'b1;
    bus_addr_i = addr;
    bus_data_i = data;
    if (addr >= `SIM_SRAM_START && addr < `SIM_SRAM_START + `SIM_SRAM_WORDS * 4 &&
        addr[1:0] == 2'b00)
      model_mem[sram_index_t'((addr - `SIM_SRAM_START) >> 2)] = data;
    if (addr == `SW_LOG_ADDR)
      log_m = {1'b1, data[7:0]};
    if (addr == `SW_STATUS_ADDR)
      follow_status(data[15:0]);
  endtask

  task automatic read_word(input sram_index_t idx);
    step(1);
    rd_index_i = idx;
    rd_chk = 1'b1;
    rd_exp = model_mem[idx];
  endtask

  task automatic apply_reset(input int n);
    step(1);
    reset_i = 1'b1;
    st_m = Boot;
    res_m = 2'b00;
    step(n);
    reset_i = 1'b0;
  endtask

  task automatic check_pads(input logic strap);
    logic [3:0] dps_exp;
    int         r;
    repeat (20) begin
      step(1);
      r = $random(seed);
      jtag_spi_n_i = strap;
      {jtag_tck_i, jtag_tms_i, jtag_tdi_i} = r[2:0];
      {spi_sck_i, spi_csb_i, spi_sdi_i} = r[5:3];
      dps_sdo_i = r[6];
      dps_exp = strap ? {jtag_tms_i, 1'b0, jtag_tdi_i, jtag_tck_i}
                      : {spi_csb_i, 1'b0, spi_sdi_i, spi_sck_i};
      #1;
      assert (dps_o == dps_exp) else begin
        check_errors++;
        $display("ERROR dps_o expected %h got %h", dps_exp, dps_o);
      end
      assert (jtag_tdo_o == (strap & dps_sdo_i)) else begin
        check_errors++;
        $display("ERROR jtag_tdo_o expected %h got %h", strap & dps_sdo_i, jtag_tdo_o);
      end
      assert (spi_sdo_o == (~strap & dps_sdo_i)) else begin
        check_errors++;
        $display("ERROR spi_sdo_o expected %h got %h", ~strap & dps_sdo_i, spi_sdo_o);
      end
    end
  endtask

  task automatic end_test(input string name);
    int err_now;
    step(4);
    err_now = assert_errors + check_errors;
    tests_run++;
    if (err_now == err_mark) begin
      $display("test %0s: ok", name);
    end else begin
      tests_failed++;
      $display("test %0s: %0d errors", name, err_now - err_mark);
    end
    err_mark = err_now;
  endtask

  initial begin
    int          i;
    int          r;
    sram_index_t written [40];
    step(16);
    reset_i = 1'b0;
    step(2);

    // Random stores below the special words, then readback
    for (i = 0; i < 40; i++) begin
      r = $random(seed);
      written[i] = sram_index_t'($unsigned(r) % 254);
      bus_write(word_addr(written[i]), $random(seed));
    end
    step(2);
    for (i = 0; i < 40; i++)
      read_word(written[i]);
    // Aliases above, below and misaligned must not land in the store
    for (i = 0; i < 40; i += 2) begin
      bus_write(word_addr(written[i]) + 32'd1024, $random(seed));
      bus_write(word_addr(written[i]) - 32'd1024, $random(seed));
      bus_write(word_addr(written[i]) + 32'd2, $random(seed));
    end
    step(2);
    for (i = 0; i < 40; i++)
      read_word(written[i]);
    end_test("store_readback");

    // Log writes mixed with plain and out-of-window writes
    for (i = 0; i < 40; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0, 2'd1: bus_write(`SW_LOG_ADDR, $random(seed));
        2'd2: bus_write(word_addr(sram_index_t'($unsigned(r) % 254)), $random(seed));
        default: bus_write(`SW_LOG_ADDR + 32'd1024, r);
      endcase
    end
    end_test("log_stream");

    bus_write(`SW_STATUS_ADDR, {16'h00a5, `STATUS_IN_TEST});
    step(3);
    bus_write(`SW_STATUS_ADDR, {16'h0000, 16'h1234});
    bus_write(`SW_STATUS_ADDR, {16'h5a00, `STATUS_PASSED});
    end_test("pass_sequence");

    // Pass without a start is ignored, fail ends it, later codes are ignored
    apply_reset(4);
    bus_write(`SW_STATUS_ADDR, {16'h0000, `STATUS_PASSED});
    step(3);
    bus_write(`SW_STATUS_ADDR, {16'h0001, `STATUS_FAILED});
    step(2);
    bus_write(`SW_STATUS_ADDR, {16'h0000, `STATUS_IN_TEST});
    bus_write(`SW_STATUS_ADDR, {16'h0000, `STATUS_PASSED});
    bus_write(`SW_STATUS_ADDR, {16'h0000, `STATUS_FAILED});
    end_test("fail_and_order");

    check_pads(1'b1);
    check_pads(1'b0);
    end_test("pad_mux");

    $display("Summary: %0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, assert_errors + check_errors);
    if (assert_errors + check_errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* logic/sw_status_top.sv */
/*
 * Software test observer top: write decoder, window store,
 * status FSM, result reporter and dps pad mux
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module sw_status_top (
  input  logic                         clk,
  input  logic                         reset_i,
  // Processor write strobe
  input  logic                         bus_we_i,
  input  sw_status_pkg::bus_addr_t     bus_addr_i,
  input  sw_status_pkg::bus_data_t     bus_data_i,
  // Store read port
  input  sw_status_pkg::sram_index_t   rd_index_i,
  output sw_status_pkg::bus_data_t     rd_data_o,
  // Pad strap and both debug sides
  input  logic                         jtag_spi_n_i,
  input  logic                         jtag_tck_i,
  input  logic                         jtag_tms_i,
  input  logic                         jtag_tdi_i,
  output logic                         jtag_tdo_o,
  input  logic                         spi_sck_i,
  input  logic                         spi_csb_i,
  input  logic                         spi_sdi_i,
  output logic                         spi_sdo_o,
  output logic [3:0]                   dps_o,
  input  logic                         dps_sdo_i,
  // Test result
  output logic                         test_done_o,
  output logic                         test_passed_o,
  output sw_status_pkg::status_state_e test_state_o,
  output logic                         log_valid_o,
  output logic [7:0]                   log_char_o
);
  import sw_status_pkg::*;

  logic         store_we;
  sram_index_t  store_index;
  bus_data_t    store_data;
  logic         status_we;
  status_code_t status_code;
  logic         log_we;
  logic [7:0]   log_char;

  bus_write_decode u_decode (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_data_i    (bus_data_i),
    .store_we_o    (store_we),
    .store_index_o (store_index),
    .store_data_o  (store_data),
    .status_we_o   (status_we),
    .status_code_o (status_code),
    .log_we_o      (log_we),
    .log_char_o    (log_char)
  );

  sim_sram_store u_store (
    .clk           (clk),
    .store_we_i    (store_we),
    .store_index_i (store_index),
    .store_data_i  (store_data),
    .rd_index_i    (rd_index_i),
    .rd_data_o     (rd_data_o)
  );

  // Tracker state feeds both the reporter and the top output
  sw_status_tracker u_tracker (
    .clk           (clk),
    .reset_i       (reset_i),
    .status_we_i   (status_we),
    .status_code_i (status_code),
    .state_o       (test_state_o)
  );

  test_result_report u_report (
    .clk           (clk),
    .reset_i       (reset_i),
    .status_we_i   (status_we),
    .status_code_i (status_code),
    .state_i       (test_state_o),
    .log_we_i      (log_we),
    .log_char_i    (log_char),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o),
    .log_valid_o   (log_valid_o),
    .log_char_o    (log_char_o)
  );

  dps_pad_mux u_pad_mux (
    .jtag_spi_n_i  (jtag_spi_n_i),
    .jtag_tck_i    (jtag_tck_i),
    .jtag_tms_i    (jtag_tms_i),
    .jtag_tdi_i    (jtag_tdi_i),
    .jtag_tdo_o    (jtag_tdo_o),
    .spi_sck_i     (spi_sck_i),
    .spi_csb_i     (spi_csb_i),
    .spi_sdi_i     (spi_sdi_i),
    .spi_sdo_o     (spi_sdo_o),
    .dps_o         (dps_o),
    .dps_sdo_i     (dps_sdo_i)
  );

endmodule

/* logic/dps_pad_mux.sv */
/*
 * Pad sharing for the dps pins between JTAG and the SPI device,
 * selected by the strap
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module dps_pad_mux (
  input  logic       jtag_spi_n_i,
  input  logic       jtag_tck_i,
  input  logic       jtag_tms_i,
  input  logic       jtag_tdi_i,
  output logic       jtag_tdo_o,
  input  logic       spi_sck_i,
  input  logic       spi_csb_i,
  input  logic       spi_sdi_i,
  output logic       spi_sdo_o,
  output logic [3:0] dps_o,
  input  logic       dps_sdo_i
);

  // Pads toward the chip
  assign dps_o[0] = jtag_spi_n_i ? jtag_tck_i : spi_sck_i;
  assign dps_o[1] = jtag_spi_n_i ? jtag_tdi_i : spi_sdi_i;
  assign dps_o[3] = jtag_spi_n_i ? jtag_tms_i : spi_csb_i;

  // Pad 2 is an input on the chip side
  assign dps_o[2] = 1'b0;

  // Return data goes only to the selected side
  assign jtag_tdo_o = jtag_spi_n_i ? dps_sdo_i : 1'b0;
  assign spi_sdo_o  = jtag_spi_n_i ? 1'b0 : dps_sdo_i;

endmodule

/* logic/test_result_report.sv */
/*
 * Test result outputs: sticky done and passed flags,
 * plus the log character stream
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module test_result_report (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         status_we_i,
  input  sw_status_pkg::status_code_t  status_code_i,
  input  sw_status_pkg::status_state_e state_i,
  input  logic                         log_we_i,
  input  logic [7:0]                   log_char_i,
  output logic                         test_done_o,
  output logic                         test_passed_o,
  output logic                         log_valid_o,
  output logic [7:0]                   log_char_o
);
  import sw_status_pkg::*;

  logic is_pass;
  logic is_fail;
  logic finish;

  assign is_pass = (status_code_i == `STATUS_PASSED);
  assign is_fail = (status_code_i == `STATUS_FAILED);

  // Same conditions the tracker uses to leave Boot or InTest for an end state
  assign finish = status_we_i &&
                  (((state_i == InTest) && (is_pass || is_fail)) ||
                   ((state_i == Boot) && is_fail));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      test_done_o   <= 1'b0;
      test_passed_o <= 1'b0;
      log_valid_o   <= 1'b0;
    end else begin
      if (finish) begin
        test_done_o   <= 1'b1;
        test_passed_o <= is_pass;
      end
      log_valid_o <= log_we_i;
    end
  end

  // Character held until the next log write
  always_ff @(posedge clk) begin
    if (log_we_i) begin
      log_char_o <= log_char_i;
    end
  end

endmodule

/* logic/sw_status_tracker.sv */
/*
 * Software test status FSM, follows the codes written
 * to the status word
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module sw_status_tracker (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         status_we_i,
  input  sw_status_pkg::status_code_t  status_code_i,
  output sw_status_pkg::status_state_e state_o
);
  import sw_status_pkg::*;

  status_state_e state_q;
  status_state_e state_d;

  always_comb begin
    state_d = state_q;
    if (status_we_i) begin
      case (state_q)
        Boot: begin
          if (status_code_i == `STATUS_IN_TEST) begin
            state_d = InTest;
          end else if (status_code_i == `STATUS_FAILED) begin
            // A failure reported before the test starts still ends it
            state_d = Failed;
          end
        end
        InTest: begin
          if (status_code_i == `STATUS_PASSED) begin
            state_d = Passed;
          end else if (status_code_i == `STATUS_FAILED) begin
            state_d = Failed;
          end
        end
        // Passed and Failed hold until reset
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= Boot;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

/* logic/sim_sram_store.sv */
/*
 * Word store behind the simulation SRAM window,
 * one write port and one registered read port
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module sim_sram_store (
  input  logic                       clk,
  input  logic                       store_we_i,
  input  sw_status_pkg::sram_index_t store_index_i,
  input  sw_status_pkg::bus_data_t   store_data_i,
  input  sw_status_pkg::sram_index_t rd_index_i,
  output sw_status_pkg::bus_data_t   rd_data_o
);
  import sw_status_pkg::*;

  // One entry per word in the window
  bus_data_t mem [`SIM_SRAM_WORDS];

  // Write port
  always_ff @(posedge clk) begin
    if (store_we_i) begin
      mem[store_index_i] <= store_data_i;
    end
  end

  // Read port
  // A same-index write in this cycle is not yet visible here
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_index_i];
  end

endmodule

/* logic/bus_write_decode.sv */
/*
 * Processor write decoder: registers each bus write and flags it as
 * a window store, a status write or a log write
 */

`timescale 1ns/1ps

`include "sw_status_consts.svh"

module bus_write_decode (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        bus_we_i,
  input  sw_status_pkg::bus_addr_t    bus_addr_i,
  input  sw_status_pkg::bus_data_t    bus_data_i,
  output logic                        store_we_o,
  output sw_status_pkg::sram_index_t  store_index_o,
  output sw_status_pkg::bus_data_t    store_data_o,
  output logic                        status_we_o,
  output sw_status_pkg::status_code_t status_code_o,
  output logic                        log_we_o,
  output logic [7:0]                  log_char_o
);
  import sw_status_pkg::*;

  bus_addr_t   offset;
  logic        in_window;
  sram_index_t index_q;
  bus_data_t   data_q;

  // Addresses below the base wrap to a large offset and fail the range check
  assign offset    = bus_addr_i - `SIM_SRAM_START;
  assign in_window = (offset < (`SIM_SRAM_WORDS * 4)) && (bus_addr_i[1:0] == 2'b00);

  // Write strobes, one cycle behind the bus
  always_ff @(posedge clk) begin
    if (reset_i) begin
      store_we_o  <= 1'b0;
      status_we_o <= 1'b0;
      log_we_o    <= 1'b0;
    end else begin
      store_we_o  <= bus_we_i && in_window;
      status_we_o <= bus_we_i && (bus_addr_i == `SW_STATUS_ADDR);
      log_we_o    <= bus_we_i && (bus_addr_i == `SW_LOG_ADDR);
    end
  end

  // Captured write payload
  always_ff @(posedge clk) begin
    if (bus_we_i) begin
      index_q <= sram_index_t'(offset >> 2);
      data_q  <= bus_data_i;
    end
  end

  assign store_index_o = index_q;
  assign store_data_o  = data_q;

  // Status code and log character are slices of the same word
  assign status_code_o = data_q[15:0];
  assign log_char_o    = data_q[7:0];

endmodule

/* logic/sw_status_pkg.sv */
/*
 * Bus address and data types, status code and store index types,
 * and the status tracker state encoding
 */

`include "sw_status_consts.svh"

package sw_status_pkg;

  // Processor data bus
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // Low 16 bits of a status write
  typedef logic [15:0] status_code_t;

  // Word index into the window
  typedef logic [$clog2(`SIM_SRAM_WORDS)-1:0] sram_index_t;

  // Software test progress
  typedef enum logic [1:0] {
    Boot   = 2'd0,
    InTest = 2'd1,
    Passed = 2'd2,
    Failed = 2'd3
  } status_state_e;

endpackage

/* logic/sw_status_consts.svh */
/*
 * Simulation SRAM window location and depth,
 * the status and log word addresses, and the software status codes
 */

`ifndef SW_STATUS_CONSTS_SVH
`define SW_STATUS_CONSTS_SVH

// Window seen by the processor data bus
`define SIM_SRAM_START 32'h1000_0000
`define SIM_SRAM_WORDS 256

// Special words at the top of the window
`define SW_STATUS_ADDR (`SIM_SRAM_START + ((`SIM_SRAM_WORDS - 1) * 4))
`define SW_LOG_ADDR    (`SIM_SRAM_START + ((`SIM_SRAM_WORDS - 2) * 4))

// Codes carried in the low half of a status write
`define STATUS_IN_TEST 16'h4354
`define STATUS_PASSED  16'h900d
`define STATUS_FAILED  16'hbaad

`endif
